/* compile.f */
+incdir+verilog
verilog/dacCodePkg.sv
verilog/dacCurrentPkg.sv
verilog/dacStageIfs.sv
verilog/dacInputDecoder.sv
verilog/cellCurrentSummer.sv
verilog/dacOutputStage.sv
verilog/currentSteeringDac.sv
tb/currentSteeringDac_assertions.sv
tb/currentSteeringDac_tb.sv

/* run.sh */
#!/bin/sh
# build and run the DAC testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module currentSteeringDac_tb -f compile.f -o simv \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"

/* tb/currentSteeringDac_tb.sv */
`timescale 1ns/10ps
`include "dac_settings.svh"

module currentSteeringDac_tb import dacCodePkg::*, dacCurrentPkg::*;;

    localparam int FULL_UNITS   = 1152; // 2+2+4+8+16+32 plus 17 cells of 64
    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_CODES = 20;
    localparam int CAL_SELECTS  = 32;   // every value of the 5-bit select
    localparam int EQUAL_LINES  = 6;
    localparam int STREAM_CODES = 40;
    localparam int APPLY_CYCLES = 5;    // drive edge, three rising edges, check edge
    localparam int APPLY_COUNT  = 2 + RANDOM_CODES + CAL_SELECTS + EQUAL_LINES + 2;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 2 + APPLY_CYCLES * APPLY_COUNT
                                  + STREAM_CODES + 4;
    localparam int TIMEOUT_NS   = 2 * HALF_PERIOD * (TOTAL_CYCLES + 50);

    typedef struct packed {
        logic     powerOn;
        lineMaskT trueBits;
        lineMaskT compBits;
        calSelT   calSel;
    } stimT;

    logic      clk;
    logic      rstN;
    logic      pdb;
    binCodeT   dataIn;
    binCodeT   dataInB;
    thermCodeT dataTherm;
    thermCodeT dataThermB;
    calSelT    dataIcal;
    currentT   iout;
    currentT   ioutb;
    currentT   ical;
    logic      outValid;
    logic      calValid;
    logic      codeError;
    int        errorCount;
    int        checkCount;

    currentSteeringDac currentSteeringDac_i (
        .clk        (clk),
        .rstN       (rstN),
        .pdb        (pdb),
        .dataIn     (dataIn),
        .dataInB    (dataInB),
        .dataTherm  (dataTherm),
        .dataThermB (dataThermB),
        .dataIcal   (dataIcal),
        .iout       (iout),
        .ioutb      (ioutb),
        .ical       (ical),
        .outValid   (outValid),
        .calValid   (calValid),
        .codeError  (codeError)
    );

    bind currentSteeringDac currentSteeringDacAssertions currentSteeringDacAssertions_i (
        .clk      (clk),
        .rstN     (rstN),
        .iout     (iout),
        .ioutb    (ioutb),
        .ical     (ical),
        .outValid (outValid),
        .calValid (calValid)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the tests did not complete", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

    // units of one line: lsb main cell with twin, binary bits, then unary cells
    function automatic int weightOf(input int line);
        if (line == 0) begin
            return 2;
        end else if (line < `NUM_BIN_LINES) begin
            return 1 << line;
        end else begin
            return `THERM_UNITS;
        end
    endfunction

    function automatic int calLineOf(input calSelT sel); // -1 for no calibration
        if (sel == '0 || int'(sel) > `NUM_LINES) begin
            return -1;
        end
        return int'(sel) - 1;
    endfunction

    function automatic stimT randomLegal(input calSelT sel);
        stimT s;
        s.powerOn  = 1'b1;
        s.trueBits = lineMaskT'($urandom);
        s.compBits = ~s.trueBits;
        s.calSel   = sel;
        return s;
    endfunction

    task automatic checkValue(input string name, input int got, input int expv);
        checkCount++;
        assert (got == expv) else begin
            errorCount++;
            $display("ERROR: %s is 0x%0h, expected 0x%0h at %0t", name, got, expv, $time);
        end
    endtask

    task automatic driveStim(input stimT s);
        pdb        = s.powerOn;
        dataIn     = s.trueBits[`NUM_BIN_LINES-1:0];
        dataInB    = s.compBits[`NUM_BIN_LINES-1:0];
        dataTherm  = s.trueBits[`NUM_LINES-1:`NUM_BIN_LINES];
        dataThermB = s.compBits[`NUM_LINES-1:`NUM_BIN_LINES];
        dataIcal   = s.calSel;
    endtask

    task automatic checkOutputs(input stimT s);
        int   expIout;
        int   expIoutb;
        int   expIcal;
        int   calLine;
        logic expError;
        expIout  = 0;
        expIoutb = 0;
        expIcal  = 0;
        expError = 1'b0;
        calLine  = calLineOf(s.calSel);
        for (int i = 0; i < `NUM_LINES; i++) begin
            if (s.trueBits[i] == s.compBits[i]) begin
                expError = 1'b1; // equal pair steers nowhere
            end
            if (s.powerOn && i != calLine) begin
                if (!s.trueBits[i] && s.compBits[i]) begin
                    expIout += weightOf(i);
                end else if (s.trueBits[i] && !s.compBits[i]) begin
                    expIoutb += weightOf(i);
                end
            end
        end
        if (s.powerOn && calLine >= 0) begin
            expIcal = (calLine == 0) ? 1 : weightOf(calLine); // line 0 gives its twin only
        end
        checkValue("iout", int'(iout), expIout);
        checkValue("ioutb", int'(ioutb), expIoutb);
        checkValue("ical", int'(ical), expIcal);
        checkValue("outValid", int'(outValid), int'(s.powerOn));
        checkValue("calValid", int'(calValid), (s.powerOn && calLine >= 0) ? 1 : 0);
        checkValue("codeError", int'(codeError), int'(expError));
    endtask

    task automatic applyAndCheck(input stimT s);
        @(negedge clk);
        driveStim(s);
        repeat (3) @(posedge clk);
        @(negedge clk);
        checkOutputs(s);
    endtask

    task automatic checkResetState();
        checkValue("iout", int'(iout), 0);
        checkValue("ioutb", int'(ioutb), 0);
        checkValue("ical", int'(ical), 0);
        checkValue("outValid", int'(outValid), 0);
        checkValue("calValid", int'(calValid), 0);
        checkValue("codeError", int'(codeError), 0);
    endtask

    task automatic testFullScale();
        stimT s;
        s = '{powerOn: 1'b1, trueBits: '0, compBits: '1, calSel: '0};
        applyAndCheck(s);
        checkValue("iout", int'(iout), FULL_UNITS);
        checkValue("ioutb", int'(ioutb), 0);
        s.trueBits = '1; // mirror case, everything to ioutb
        s.compBits = '0;
        applyAndCheck(s);
        checkValue("ioutb", int'(ioutb), FULL_UNITS);
    endtask

    task automatic testRandomCodes();
        stimT s;
        repeat (RANDOM_CODES) begin
            s = randomLegal('0);
            applyAndCheck(s);
            checkValue("iout+ioutb", int'(iout) + int'(ioutb), FULL_UNITS);
        end
    endtask

    task automatic testCalibration();
        stimT s;
        for (int k = 0; k < CAL_SELECTS; k++) begin
            s = randomLegal(calSelT'(k));
            applyAndCheck(s);
            if (k >= 1 && k <= `NUM_LINES) begin
                checkValue("iout+ioutb", int'(iout) + int'(ioutb),
                           FULL_UNITS - weightOf(k - 1)); // full weight leaves both sums
                checkValue("ical", int'(ical), (k == 1) ? 1 : weightOf(k - 1));
                checkValue("calValid", int'(calValid), 1);
            end else begin
                checkValue("ical", int'(ical), 0);
                checkValue("calValid", int'(calValid), 0);
            end
        end
    endtask

    task automatic testEqualPair();
        int   lines[EQUAL_LINES] = '{0, 3, 5, 6, 14, 22};
        stimT s;
        for (int n = 0; n < EQUAL_LINES; n++) begin
            s = randomLegal('0);
            s.trueBits[lines[n]] = n[0]; // both low or both high
            s.compBits[lines[n]] = n[0];
            applyAndCheck(s);
            checkValue("codeError", int'(codeError), 1);
            checkValue("iout+ioutb", int'(iout) + int'(ioutb), FULL_UNITS - weightOf(lines[n]));
        end
    endtask

    task automatic testPowerDown();
        stimT s;
        s = randomLegal(calSelT'(9));
        s.powerOn = 1'b0;
        applyAndCheck(s);
        checkValue("outValid", int'(outValid), 0);
        checkValue("calValid", int'(calValid), 0);
        checkValue("iout+ioutb+ical", int'(iout) + int'(ioutb) + int'(ical), 0);
        s.powerOn = 1'b1; // same code comes back
        applyAndCheck(s);
        checkValue("calValid", int'(calValid), 1);
    endtask

    task automatic testBackToBack();
        stimT pending[$];
        stimT s;
        stimT expected;
        int   line;
        for (int n = 0; n < STREAM_CODES + 3; n++) begin
            @(negedge clk);
            if (n >= 3) begin
                expected = pending.pop_front(); // set driven three edges ago
                checkOutputs(expected);
            end
            if (n < STREAM_CODES) begin
                s = randomLegal(calSelT'($urandom_range(0, 31)));
                if ($urandom_range(0, 7) == 0) begin
                    s.powerOn = 1'b0;
                end
                if ($urandom_range(0, 5) == 0) begin
                    line = int'($urandom_range(0, `NUM_LINES - 1));
                    s.compBits[line] = s.trueBits[line];
                end
                driveStim(s);
                pending.push_back(s);
            end
        end
    endtask

    initial begin
        void'($urandom(32'hdcaa));
        errorCount = 0;
        checkCount = 0;
        rstN       = 1'b0;
        pdb        = 1'b0;
        dataIn     = '0;
        dataInB    = '1;
        dataTherm  = '0;
        dataThermB = '1;
        dataIcal   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        checkResetState();
        rstN = 1'b1;
        testFullScale();
        testRandomCodes();
        testCalibration();
        testEqualPair();
        testPowerDown();
        testBackToBack();
        $display("checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tb/currentSteeringDac_assertions.sv */
`timescale 1ns/10ps

module currentSteeringDacAssertions import dacCurrentPkg::*; (
    input logic    clk,
    input logic    rstN,
    input currentT iout,
    input currentT ioutb,
    input currentT ical,
    input logic    outValid,
    input logic    calValid
);

    int totalUnits;   // everything the block sources at once

    assign totalUnits = int'(iout) + int'(ioutb) + int'(ical);

    // a low valid flag stands for high impedance
    property zeroWhenInvalid;
        @(posedge clk) disable iff (!rstN)
            !outValid |-> (iout == '0 && ioutb == '0 && ical == '0);
    endproperty

    property calNeedsPower;
        @(posedge clk) disable iff (!rstN)
            calValid |-> outValid;
    endproperty

    property withinFullScale;
        @(posedge clk) disable iff (!rstN)
            totalUnits <= int'(FULL_SCALE);
    endproperty

    zeroWhenInvalidA: assert property (zeroWhenInvalid)
        else $error("currents are not zero while outValid is low");

    calNeedsPowerA: assert property (calNeedsPower)
        else $error("calValid is high while outValid is low");

    withinFullScaleA: assert property (withinFullScale)
        else $error("iout + ioutb + ical = %0d exceeds full scale", totalUnits);

endmodule

/* verilog/currentSteeringDac.sv */
`timescale 1ns/10ps

module currentSteeringDac import dacCodePkg::*, dacCurrentPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      pdb,         // power down when low
    input  binCodeT   dataIn,      // binary lines, true side
    input  binCodeT   dataInB,     // binary lines, complement side
    input  thermCodeT dataTherm,
    input  thermCodeT dataThermB,
    input  calSelT    dataIcal,    // line k-1 to ical, 0 for none
    output currentT   iout,
    output currentT   ioutb,
    output currentT   ical,
    output logic      outValid,
    output logic      calValid,
    output logic      codeError
);

    steerIf steerIf_i ();
    sumIf   sumIf_i ();

    // decode, sum and output each add one cycle
    dacInputDecoder dacInputDecoder_i (
        .clk        (clk),
        .rstN       (rstN),
        .pdb        (pdb),
        .dataIn     (dataIn),
        .dataInB    (dataInB),
        .dataTherm  (dataTherm),
        .dataThermB (dataThermB),
        .dataIcal   (dataIcal),
        .steer      (steerIf_i.decoder)
    );

    cellCurrentSummer cellCurrentSummer_i (
        .clk   (clk),
        .rstN  (rstN),
        .steer (steerIf_i.summer),
        .sums  (sumIf_i.summer)
    );

    dacOutputStage dacOutputStage_i (
        .clk       (clk),
        .rstN      (rstN),
        .sums      (sumIf_i.outStage),
        .iout      (iout),
        .ioutb     (ioutb),
        .ical      (ical),
        .outValid  (outValid),
        .calValid  (calValid),
        .codeError (codeError)
    );

endmodule

/* verilog/dacOutputStage.sv */
`timescale 1ns/10ps
`include "dac_settings.svh"

module dacOutputStage import dacCodePkg::*, dacCurrentPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    sumIf.outStage  sums,
    output currentT iout,
    output currentT ioutb,
    output currentT ical,
    output logic    outValid,    // low stands for high impedance
    output logic    calValid,
    output logic    codeError
);

    currentT icalNext;

    always_comb begin
        if (!sums.calEnable) begin
            icalNext = '0;
        end else if (sums.calLine == lineIdxT'(0)) begin
            icalNext = currentT'(`RED_UNITS); // only the twin, main lsb cell idles
        end else begin
            icalNext = lineWeight[sums.calLine];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            iout      <= '0;
            ioutb     <= '0;
            ical      <= '0;
            outValid  <= 1'b0;
            calValid  <= 1'b0;
            codeError <= 1'b0;
        end else begin
            iout      <= sums.ioutSum;
            ioutb     <= sums.ioutbSum;
            ical      <= icalNext;
            outValid  <= sums.powered;
            calValid  <= sums.calEnable;
            codeError <= sums.codeError;
        end
    end

endmodule

/* verilog/cellCurrentSummer.sv */
`timescale 1ns/10ps
`include "dac_settings.svh"

module cellCurrentSummer import dacCodePkg::*, dacCurrentPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    steerIf.summer steer,
    sumIf.summer   sums
);

    lineMaskT outMask;
    lineMaskT outbMask;
    currentT  outAcc;    // units headed for iout
    currentT  outbAcc;   // units headed for ioutb

    assign outMask  = steer.toOut;
    assign outbMask = steer.toOutb;

    // both masks are disjoint, so the two sums never exceed full scale together
    always_comb begin
        outAcc  = '0;
        outbAcc = '0;
        for (int i = 0; i < `NUM_LINES; i++) begin
            if (outMask[i]) begin
                outAcc = outAcc + lineWeight[i];
            end
            if (outbMask[i]) begin
                outbAcc = outbAcc + lineWeight[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sums.ioutSum   <= '0;
            sums.ioutbSum  <= '0;
            sums.calLine   <= '0;
            sums.calEnable <= 1'b0;
            sums.powered   <= 1'b0;
            sums.codeError <= 1'b0;
        end else begin
            sums.ioutSum   <= outAcc;
            sums.ioutbSum  <= outbAcc;
            sums.calLine   <= steer.calLine;   // side info keeps pace with the sums
            sums.calEnable <= steer.calEnable;
            sums.powered   <= steer.powered;
            sums.codeError <= steer.codeError;
        end
    end

endmodule

/* verilog/dacInputDecoder.sv */
`timescale 1ns/10ps

module dacInputDecoder import dacCodePkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      pdb,         // low powers the block down
    input  binCodeT   dataIn,
    input  binCodeT   dataInB,
    input  thermCodeT dataTherm,
    input  thermCodeT dataThermB,
    input  calSelT    dataIcal,
    steerIf.decoder   steer
);

    lineMaskT trueBits;
    lineMaskT compBits;
    lineMaskT pairEqual;   // lines whose pair steers nowhere
    lineMaskT calMask;     // line taken out for calibration
    lineMaskT outNext;
    lineMaskT outbNext;
    logic     calEnNext;
    lineIdxT  calLineNext;

    assign trueBits  = joinCode(dataTherm, dataIn);
    assign compBits  = joinCode(dataThermB, dataInB);
    assign pairEqual = ~(trueBits ^ compBits);

    // calibration only while powered
    assign calEnNext   = pdb && calSelValid(dataIcal);
    assign calLineNext = calSelToLine(dataIcal);
    assign calMask     = calEnNext ? (lineMaskT'(1) << calLineNext) : '0;

    // true low steers to iout, true high steers to ioutb
    assign outNext  = ~trueBits & compBits & ~calMask;
    assign outbNext = trueBits & ~compBits & ~calMask;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            steer.toOut     <= '0;
            steer.toOutb    <= '0;
            steer.calLine   <= '0;
            steer.calEnable <= 1'b0;
            steer.powered   <= 1'b0;
            steer.codeError <= 1'b0;
        end else begin
            if (pdb) begin
                steer.toOut  <= outNext;
                steer.toOutb <= outbNext;
            end else begin
                steer.toOut  <= '0; // no current flows when powered down
                steer.toOutb <= '0;
            end
            steer.calLine   <= calEnNext ? calLineNext : '0;
            steer.calEnable <= calEnNext;
            steer.powered   <= pdb;
            steer.codeError <= |pairEqual;
        end
    end

endmodule

/* verilog/dacStageIfs.sv */
`timescale 1ns/10ps

// decoded steering per line, decoder to summer
interface steerIf import dacCodePkg::*; ();

    lineMaskT toOut;      // lines steered to iout
    lineMaskT toOutb;     // lines steered to ioutb
    lineIdxT  calLine;    // line routed to ical
    logic     calEnable;
    logic     powered;    // pdb as sampled with this code
    logic     codeError;  // at least one equal pair

    modport decoder (
        output toOut, toOutb, calLine, calEnable, powered, codeError
    );

    modport summer (
        input toOut, toOutb, calLine, calEnable, powered, codeError
    );

endinterface

// summed currents, summer to output stage
interface sumIf import dacCodePkg::*, dacCurrentPkg::*; ();

    currentT ioutSum;     // units on iout
    currentT ioutbSum;    // units on ioutb
    lineIdxT calLine;
    logic    calEnable;
    logic    powered;
    logic    codeError;

    modport summer (
        output ioutSum, ioutbSum, calLine, calEnable, powered, codeError
    );

    modport outStage (
        input ioutSum, ioutbSum, calLine, calEnable, powered, codeError
    );

endinterface

/* verilog/dacCurrentPkg.sv */
`include "dac_settings.svh"

package dacCurrentPkg;

    typedef logic [`CURRENT_WIDTH-1:0] currentT; // current as a count of unit cells

    typedef currentT weightTableT [`NUM_LINES];

    // weight of each line in units
    // line 0 is the main lsb cell together with its redundant twin
    localparam weightTableT lineWeight = '{
        0:       currentT'(2 * `RED_UNITS),
        1:       currentT'(2),
        2:       currentT'(4),
        3:       currentT'(8),
        4:       currentT'(16),
        5:       currentT'(32),
        default: currentT'(`THERM_UNITS) // all thermometer cells
    };

    function automatic currentT tableSum(input weightTableT weights);
        int acc;
        acc = 0;
        for (int i = 0; i < `NUM_LINES; i++) begin
            acc += int'(weights[i]);
        end
        return currentT'(acc);
    endfunction

    // every cell steered to one side
    localparam currentT FULL_SCALE = tableSum(lineWeight);

endpackage

/* verilog/dacCodePkg.sv */
`include "dac_settings.svh"

package dacCodePkg;

    typedef logic [`NUM_BIN_LINES-1:0]   binCodeT;   // binary part of the code
    typedef logic [`NUM_THERM_LINES-1:0] thermCodeT; // thermometer part of the code
    typedef logic [`NUM_LINES-1:0]       lineMaskT;  // one bit per line, bit 0 is binary bit 0
    typedef logic [`CAL_SEL_WIDTH-1:0]   calSelT;    // 0 or above NUM_LINES means no calibration
    typedef logic [`CAL_SEL_WIDTH-1:0]   lineIdxT;   // index of a single line

    // binary lines sit below the thermometer lines
    function automatic lineMaskT joinCode(input thermCodeT therm, input binCodeT bin);
        return {therm, bin};
    endfunction

    // a select only calibrates when it names an existing line
    function automatic logic calSelValid(input calSelT sel);
        return (sel != '0) && (sel <= calSelT'(`NUM_LINES));
    endfunction

    function automatic lineIdxT calSelToLine(input calSelT sel);
        lineIdxT idx;
        idx = '0;
        if (calSelValid(sel)) begin
            idx = lineIdxT'(sel - 1'b1); // select k picks line k-1
        end
        return idx;
    endfunction

endpackage

/* verilog/dac_settings.svh */
`ifndef DAC_SETTINGS_SVH
`define DAC_SETTINGS_SVH

// line organisation of the converter
`define NUM_BIN_LINES   6    // binary lines, bit 0 carries its redundant twin
`define NUM_THERM_LINES 17   // unary msb cells
`define NUM_LINES       (`NUM_BIN_LINES + `NUM_THERM_LINES)

// calibration select, 1..NUM_LINES picks line k-1
`define CAL_SEL_WIDTH   5

// currents are counted in unit cells of iref/160
`define CURRENT_WIDTH   11   // holds full scale of 1152 units

// unit weights
`define THERM_UNITS     64   // one thermometer cell
`define RED_UNITS       1    // redundant lsb cell alone

`endif
